/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := tb_zynq_host_bridge
FILELIST  := build.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_TEXT := Result: PASSED

SOURCES := $(wildcard logic/*.sv) $(wildcard test/*.sv) $(wildcard test/*.svh)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source file or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* build.f */
+incdir+test
logic/host_bridge_pkg.sv
logic/csr_decode.sv
logic/csr_regs.sv
logic/addr_xlate.sv
logic/mem_profiler.sv
logic/zynq_host_bridge.sv
test/tb_zynq_host_bridge.sv

/* logic/addr_xlate.sv */
`timescale 1ns/1ps

module addr_xlate
(
   input  logic [host_bridge_pkg::host_addr_width-1:0] host_addr_i,
   input  logic dram_v_i,
   input  host_bridge_pkg::dram_addr_u dram_addr_i,
   input  logic [host_bridge_pkg::data_width-1:0] dram_base_i,
   output logic [host_bridge_pkg::data_width-1:0] bp_addr_o,
   output logic [host_bridge_pkg::data_width-1:0] mem_addr_o,
   output logic mem_range_err_o
);

   import host_bridge_pkg::*;

   logic [data_width-1:0] dram_offset;

   // the host window arrives through the GP1 port with 0x8000_0000 removed
   //   GP1 0x0000_0000 .. 0x0FFF_FFFF maps to processor 0x8000_0000 (DRAM)
   //   GP1 0x2000_0000 .. 0x2FFF_FFFF maps to processor 0x0000_0000 (local)
   // bit 29 tells the two windows apart and flips into the processor's top bit,
   // both windows are 256 MB so bit 28 carries no address
   assign bp_addr_o = {~host_addr_i[29], 3'b000, host_addr_i[27:0]};

   // flipping bit 31 strips the processor DRAM base, which is cheaper
   // than a subtract since the base is a single bit
   assign dram_offset = dram_addr_i.raw ^ dram_base_bp;

   // the offset lands inside the block the PS allocated for us
   assign mem_addr_o = dram_offset + dram_base_i;

   // anything past the allocation would scribble over PS memory
   assign mem_range_err_o = dram_v_i & (dram_offset >= dram_limit);

   // a valid request must carry a real address or the translated
   // PS address and the range flag mean nothing
   always_comb
   begin
      if (dram_v_i)
      begin
         dram_addr_known: assert final (!$isunknown(dram_addr_i.raw))
            else $error("addr_xlate: unknown DRAM address with valid high");
      end
   end

endmodule

/* logic/csr_decode.sv */
`timescale 1ns/1ps

module csr_decode
(
   input  logic psel_i,
   input  logic penable_i,
   input  logic pwrite_i,
   input  logic [host_bridge_pkg::apb_addr_width-1:0] paddr_i,
   output logic [host_bridge_pkg::reg_idx_width-1:0] reg_idx_o,
   output logic reg_we_o,
   output logic pready_o,
   output logic pslverr_o
);

   import host_bridge_pkg::*;

   logic access;
   logic aligned;
   logic in_map;
   logic read_only;

   // the access phase is the only cycle in which the shell responds
   assign access = psel_i & penable_i;

   // registers are whole words, so the two low address bits must be zero
   assign aligned = (paddr_i[1:0] == 2'b00);

   // the map is dense from ctrl up to the last profiler word
   assign in_map = (paddr_i <= reg_prof3);

   // everything from the first profiler word upwards is read only
   assign read_only = (paddr_i >= reg_prof0);

   assign reg_idx_o = paddr_i[2 +: reg_idx_width];

   // no wait states, every access phase completes at once
   assign pready_o = access;

   // a write only reaches storage when the transfer is legal
   assign reg_we_o = access & pwrite_i & aligned & in_map & ~read_only;

   // an erroring transfer leaves every register untouched
   assign pslverr_o = access & (~aligned | ~in_map | (pwrite_i & read_only));

   // the APB setup phase must come before the access phase, so psel is
   // already high by the time penable rises
   penable_needs_psel: assert property (@(posedge penable_i) psel_i)
      else $error("csr_decode: penable rose without psel");

endmodule

/* logic/csr_regs.sv */
`timescale 1ns/1ps

module csr_regs
(
   input  logic aclk_i,
   input  logic rst_n_i,
   input  logic [host_bridge_pkg::reg_idx_width-1:0] reg_idx_i,
   input  logic reg_we_i,
   input  logic [host_bridge_pkg::data_width-1:0] pwdata_i,
   input  logic [host_bridge_pkg::prof_regions-1:0] prof_map_i,
   output logic [host_bridge_pkg::data_width-1:0] prdata_o,
   output logic [host_bridge_pkg::data_width-1:0] dram_base_o,
   output logic bp_run_o
);

   import host_bridge_pkg::*;

   // ctrl bit 0 lets the processor out of reset
   logic ctrl_run_r;

   // set by software once the PS has allocated DRAM for the processor
   logic alloc_r;

   // physical address of that allocation in PS DRAM
   logic [data_width-1:0] base_r;

   always_ff @(posedge aclk_i)
   begin
      if (!rst_n_i)
      begin
         ctrl_run_r <= 1'b0;
         alloc_r <= 1'b0;
         base_r <= '0;
      end
      else if (reg_we_i)
      begin
         // the decoder never raises the write enable for read-only words
         case (reg_idx_i)
            reg_ctrl[2 +: reg_idx_width]:
            begin
               ctrl_run_r <= pwdata_i[0];
            end
            reg_alloc[2 +: reg_idx_width]:
            begin
               alloc_r <= pwdata_i[0];
            end
            reg_base[2 +: reg_idx_width]:
            begin
               base_r <= pwdata_i;
            end
            default:
            begin
               base_r <= base_r;
            end
         endcase
      end
   end

   // read data is combinational from the index, so it is ready in the
   // access phase together with pready
   always_comb
   begin
      case (reg_idx_i)
         reg_ctrl[2 +: reg_idx_width]:
            prdata_o = {{(data_width-1){1'b0}}, ctrl_run_r};
         reg_alloc[2 +: reg_idx_width]:
            prdata_o = {{(data_width-1){1'b0}}, alloc_r};
         reg_base[2 +: reg_idx_width]:
            prdata_o = base_r;
         // profiler word n holds regions 32n to 32n+31
         reg_prof0[2 +: reg_idx_width]:
            prdata_o = prof_map_i[0 +: data_width];
         reg_prof1[2 +: reg_idx_width]:
            prdata_o = prof_map_i[data_width +: data_width];
         reg_prof2[2 +: reg_idx_width]:
            prdata_o = prof_map_i[2*data_width +: data_width];
         reg_prof3[2 +: reg_idx_width]:
            prdata_o = prof_map_i[3*data_width +: data_width];
         default:
            prdata_o = '0;
      endcase
   end

   assign dram_base_o = base_r;
   assign bp_run_o = ctrl_run_r;

endmodule

/* logic/host_bridge_pkg.sv */
package host_bridge_pkg;

   // APB register bus and processor address widths
   localparam int apb_addr_width = 8;
   localparam int data_width = 32;

   // the PS host port drops the top two address bits
   localparam int host_addr_width = 30;

   // register index is the word offset within the shell
   localparam int reg_idx_width = 3;

   // register map, byte offsets
   localparam logic [apb_addr_width-1:0] reg_ctrl = 8'h00;
   localparam logic [apb_addr_width-1:0] reg_alloc = 8'h04;
   localparam logic [apb_addr_width-1:0] reg_base = 8'h08;
   localparam logic [apb_addr_width-1:0] reg_prof0 = 8'h0C;
   localparam logic [apb_addr_width-1:0] reg_prof1 = 8'h10;
   localparam logic [apb_addr_width-1:0] reg_prof2 = 8'h14;
   localparam logic [apb_addr_width-1:0] reg_prof3 = 8'h18;

   // processor DRAM starts here in its own physical map
   localparam logic [data_width-1:0] dram_base_bp = 32'h8000_0000;

   // highest legal DRAM offset plus one (120 MiB)
   localparam logic [data_width-1:0] dram_limit = 32'h0780_0000;

   // the profiler splits the lower 1 GiB of offsets into 8 MiB regions
   localparam int prof_regions = 128;
   localparam int prof_region_width = $clog2(prof_regions);

   // a processor DRAM address, seen either as a plain word for translation
   // or split into the profiler region and the offset inside it
   typedef union packed {
      logic [data_width-1:0] raw;
      struct packed {
         logic [1:0] hi;
         logic [prof_region_width-1:0] region;
         logic [data_width-3-prof_region_width:0] offset;
      } prof;
   } dram_addr_u;

endpackage

/* logic/mem_profiler.sv */
`timescale 1ns/1ps

module mem_profiler
(
   input  logic aclk_i,
   input  logic rst_n_i,
   input  logic bp_run_i,
   input  logic dram_v_i,
   input  host_bridge_pkg::dram_addr_u dram_addr_i,
   output logic [host_bridge_pkg::prof_regions-1:0] prof_map_o
);

   import host_bridge_pkg::*;

   // one sticky bit per 8 MiB region, so software can see how much
   // DRAM a program has actually touched
   logic [prof_regions-1:0] prof_map_r;

   always_ff @(posedge aclk_i)
   begin
      // a fresh run starts with an empty map
      if (!rst_n_i || !bp_run_i)
      begin
         prof_map_r <= '0;
      end
      else if (dram_v_i)
      begin
         // the region field sits below bit 30, which is the same in the
         // raw address and in the offset after the base is stripped
         prof_map_r[dram_addr_i.prof.region] <= 1'b1;
      end
   end

   assign prof_map_o = prof_map_r;

endmodule

/* logic/zynq_host_bridge.sv */
`timescale 1ns/1ps

module zynq_host_bridge
(
   input  logic aclk_i,
   input  logic rst_n_i,
   output logic bp_reset_n_o,

   // APB slave for the register shell
   input  logic psel_i,
   input  logic penable_i,
   input  logic pwrite_i,
   input  logic [host_bridge_pkg::apb_addr_width-1:0] paddr_i,
   input  logic [host_bridge_pkg::data_width-1:0] pwdata_i,
   output logic pready_o,
   output logic [host_bridge_pkg::data_width-1:0] prdata_o,
   output logic pslverr_o,

   // host window into the processor's address map
   input  logic [host_bridge_pkg::host_addr_width-1:0] host_addr_i,
   output logic [host_bridge_pkg::data_width-1:0] bp_addr_o,

   // processor DRAM request towards PS DRAM
   input  logic dram_v_i,
   input  logic [host_bridge_pkg::data_width-1:0] dram_addr_i,
   output logic [host_bridge_pkg::data_width-1:0] mem_addr_o,
   output logic mem_range_err_o
);

   import host_bridge_pkg::*;

   logic [reg_idx_width-1:0] reg_idx_w;
   logic reg_we_w;
   logic [data_width-1:0] dram_base_w;
   logic bp_run_w;
   logic [prof_regions-1:0] prof_map_w;
   dram_addr_u dram_addr_w;

   assign dram_addr_w.raw = dram_addr_i;

   // the processor stays in reset until software sets ctrl bit 0, so a new
   // program can be loaded without reconfiguring the FPGA
   assign bp_reset_n_o = rst_n_i & bp_run_w;

   csr_decode u_decode
   (
      .psel_i    (psel_i),
      .penable_i (penable_i),
      .pwrite_i  (pwrite_i),
      .paddr_i   (paddr_i),
      .reg_idx_o (reg_idx_w),
      .reg_we_o  (reg_we_w),
      .pready_o  (pready_o),
      .pslverr_o (pslverr_o)
   );

   csr_regs u_regs
   (
      .aclk_i      (aclk_i),
      .rst_n_i     (rst_n_i),
      .reg_idx_i   (reg_idx_w),
      .reg_we_i    (reg_we_w),
      .pwdata_i    (pwdata_i),
      .prof_map_i  (prof_map_w),
      .prdata_o    (prdata_o),
      .dram_base_o (dram_base_w),
      .bp_run_o    (bp_run_w)
   );

   addr_xlate u_xlate
   (
      .host_addr_i     (host_addr_i),
      .dram_v_i        (dram_v_i),
      .dram_addr_i     (dram_addr_w),
      .dram_base_i     (dram_base_w),
      .bp_addr_o       (bp_addr_o),
      .mem_addr_o      (mem_addr_o),
      .mem_range_err_o (mem_range_err_o)
   );

   mem_profiler u_profiler
   (
      .aclk_i      (aclk_i),
      .rst_n_i     (rst_n_i),
      .bp_run_i    (bp_run_w),
      .dram_v_i    (dram_v_i),
      .dram_addr_i (dram_addr_w),
      .prof_map_o  (prof_map_w)
   );

   // the access phase must follow its setup phase with the same address
   // and direction, since the shell only decodes in the access phase
   setup_then_access: assert property (@(posedge aclk_i) disable iff (!rst_n_i)
      (psel_i && !penable_i) |=> (psel_i && penable_i && $stable(paddr_i)
         && $stable(pwrite_i)))
      else $error("zynq_host_bridge: APB setup phase not followed by its access phase");

endmodule

/* test/tb_tasks.svh */
// one APB transfer, setup phase first, then the access phase until pready
task automatic apb_transfer(input logic is_write, input logic [7:0] addr,
   input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
   int waited;
   waited = 0;
   @(posedge aclk);
   psel <= 1'b1;
   penable <= 1'b0;
   pwrite <= is_write;
   paddr <= addr;
   pwdata <= wdata;
   @(posedge aclk);
   penable <= 1'b1;
   @(negedge aclk);
   while (pready !== 1'b1 && waited < apb_wait_limit)
   begin
      waited++;
      @(negedge aclk);
   end
   if (pready !== 1'b1)
   begin
      error_count++;
      $display("APB transfer to offset %h never saw pready", addr);
   end
   rdata = prdata;
   err = pslverr;
   // the access phase ends at this edge, which is where a write lands
   @(posedge aclk);
   psel <= 1'b0;
   penable <= 1'b0;
   pwrite <= 1'b0;
endtask

task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
   logic [31:0] ignored;
   apb_transfer(1'b1, addr, data, ignored, err);
endtask

task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
   apb_transfer(1'b0, addr, 32'h0, data, err);
endtask

task automatic reset_values_test();
   logic [31:0] rdata;
   logic err;
   int i;
   @(negedge aclk);
   check_value("reset bp_reset_n", 32'h0, 32'(bp_reset_n));
   for (i = 0; i < 7; i++)
   begin
      apb_read(8'(4 * i), rdata, err);
      check_value("reset readback", 32'h0, rdata);
      check_value("reset pslverr", 32'h0, 32'(err));
   end
endtask

task automatic register_access_test();
   logic [31:0] word;
   logic [31:0] rdata;
   logic err;
   int i;
   // first pass sets the run bit, second pass clears it again
   for (i = 0; i < 2; i++)
   begin
      word = lfsr_bits(32);
      word[0] = (i == 0);
      apb_write(off_ctrl, word, err);
      exp_ctrl = word[0];
      check_value("ctrl write pslverr", 32'h0, 32'(err));
      @(negedge aclk);
      check_value("ctrl bp_reset_n", 32'(exp_ctrl), 32'(bp_reset_n));
      apb_read(off_ctrl, rdata, err);
      check_value("ctrl readback", 32'(exp_ctrl), rdata);
      word = lfsr_bits(32);
      word[0] = (i != 0);
      apb_write(off_alloc, word, err);
      exp_alloc = word[0];
      apb_read(off_alloc, rdata, err);
      check_value("alloc readback", 32'(exp_alloc), rdata);
      exp_base = lfsr_bits(32);
      apb_write(off_base, exp_base, err);
      apb_read(off_base, rdata, err);
      check_value("base readback", exp_base, rdata);
   end
endtask

task automatic error_response_test();
   logic [31:0] rdata;
   logic err;
   // each bad offset aliases a writable register and carries the inverse
   // of its stored value, so a leak would show
   apb_write(8'h40, {32{~exp_ctrl}}, err);
   check_value("unmapped write pslverr", 32'h1, 32'(err));
   apb_read(8'h1C, rdata, err);
   check_value("unmapped read pslverr", 32'h1, 32'(err));
   apb_write(8'h05, {32{~exp_alloc}}, err);
   check_value("unaligned write pslverr", 32'h1, 32'(err));
   apb_write(8'h0A, ~exp_base, err);
   check_value("unaligned base pslverr", 32'h1, 32'(err));
   apb_write(8'h10, 32'hFFFF_FFFF, err);
   check_value("profiler write pslverr", 32'h1, 32'(err));
   apb_read(off_ctrl, rdata, err);
   check_value("ctrl after errors", 32'(exp_ctrl), rdata);
   apb_read(off_alloc, rdata, err);
   check_value("alloc after errors", 32'(exp_alloc), rdata);
   apb_read(off_base, rdata, err);
   check_value("base after errors", exp_base, rdata);
   apb_read(8'h10, rdata, err);
   check_value("profiler after errors", 32'h0, rdata);
endtask

task automatic host_window_test();
   logic [31:0] word;
   logic [31:0] expected;
   int i;
   for (i = 0; i < host_samples; i++)
   begin
      word = lfsr_bits(30);
      // bit 29 clear is the DRAM window at 0x8000_0000, set is local space at 0
      expected = (word[29] ? 32'h0000_0000 : 32'h8000_0000) | {4'h0, word[27:0]};
      @(posedge aclk);
      host_addr <= word[29:0];
      @(negedge aclk);
      check_value("host window", expected, bp_addr);
   end
endtask

task automatic dram_translate_test();
   logic [31:0] offset;
   logic valid;
   logic err;
   int i;
   exp_base = lfsr_bits(32);
   apb_write(off_base, exp_base, err);
   for (i = 0; i < dram_samples; i++)
   begin
      valid = lfsr_bit() | (i < 2);
      // short offsets land near the 120 MiB limit so both sides get hit
      if (lfsr_bit())
         offset = lfsr_bits(27);
      else
         offset = lfsr_bits(32);
      if (i == 0)
         offset = dram_limit_bytes - 32'd1;
      if (i == 1)
         offset = dram_limit_bytes;
      @(posedge aclk);
      dram_v <= valid;
      dram_addr <= offset ^ 32'h8000_0000;
      @(negedge aclk);
      check_value("dram address", offset + exp_base, mem_addr);
      check_value("dram range", 32'(valid & (offset >= dram_limit_bytes)), 32'(mem_range_err));
   end
   @(posedge aclk);
   dram_v <= 1'b0;
endtask

task automatic profiler_test();
   logic [127:0] exp_map;
   logic [31:0] word;
   logic [31:0] rdata;
   logic err;
   int i;
   exp_map = '0;
   // a fresh release of the processor starts from an empty profile
   apb_write(off_ctrl, 32'h0, err);
   apb_write(off_ctrl, 32'h1, err);
   exp_ctrl = 1'b1;
   for (i = 0; i < prof_requests; i++)
   begin
      word = lfsr_bits(32);
      exp_map[word[29:23]] = 1'b1;
      @(posedge aclk);
      dram_v <= 1'b1;
      dram_addr <= word;
   end
   @(posedge aclk);
   dram_v <= 1'b0;
   for (i = 0; i < 4; i++)
   begin
      apb_read(off_prof0 + 8'(4 * i), rdata, err);
      check_value("profiler map", exp_map[32 * i +: 32], rdata);
   end
   apb_write(off_ctrl, 32'h0, err);
   apb_write(off_ctrl, 32'h1, err);
   for (i = 0; i < 4; i++)
   begin
      apb_read(off_prof0 + 8'(4 * i), rdata, err);
      check_value("profiler cleared", 32'h0, rdata);
   end
endtask

/* test/tb_zynq_host_bridge.sv */
`timescale 1ns/1ps

module tb_zynq_host_bridge;

   localparam int clk_period = 40;
   localparam int reset_cycles = 3;
   localparam int apb_wait_limit = 8;

   // lengths of the directed tests, the watchdog is sized from them
   localparam int apb_transfers = 64;
   localparam int host_samples = 16;
   localparam int dram_samples = 24;
   localparam int prof_requests = 40;
   localparam int run_cycles = reset_cycles + apb_transfers * (3 + apb_wait_limit)
      + host_samples + dram_samples + prof_requests;
   localparam int watchdog_cycles = 4 * run_cycles;

   // register offsets and the DRAM window as the bridge defines them
   localparam logic [7:0] off_ctrl = 8'h00;
   localparam logic [7:0] off_alloc = 8'h04;
   localparam logic [7:0] off_base = 8'h08;
   localparam logic [7:0] off_prof0 = 8'h0C;
   localparam logic [31:0] dram_limit_bytes = 32'd120 << 20;

   logic aclk;
   logic rst_n;
   logic bp_reset_n;
   logic psel;
   logic penable;
   logic pwrite;
   logic [7:0] paddr;
   logic [31:0] pwdata;
   logic pready;
   logic [31:0] prdata;
   logic pslverr;
   logic [29:0] host_addr;
   logic [31:0] bp_addr;
   logic dram_v;
   logic [31:0] dram_addr;
   logic [31:0] mem_addr;
   logic mem_range_err;

   int error_count;
   int check_count;
   logic [31:0] lfsr_state;

   // register contents the shell is expected to hold
   logic exp_ctrl;
   logic exp_alloc;
   logic [31:0] exp_base;

   zynq_host_bridge u_dut
   (
      .aclk_i          (aclk),
      .rst_n_i         (rst_n),
      .bp_reset_n_o    (bp_reset_n),
      .psel_i          (psel),
      .penable_i       (penable),
      .pwrite_i        (pwrite),
      .paddr_i         (paddr),
      .pwdata_i        (pwdata),
      .pready_o        (pready),
      .prdata_o        (prdata),
      .pslverr_o       (pslverr),
      .host_addr_i     (host_addr),
      .bp_addr_o       (bp_addr),
      .dram_v_i        (dram_v),
      .dram_addr_i     (dram_addr),
      .mem_addr_o      (mem_addr),
      .mem_range_err_o (mem_range_err)
   );

   initial
   begin
      aclk = 1'b0;
      forever #(clk_period / 2) aclk = ~aclk;
   end

   initial
   begin
      #(watchdog_cycles * clk_period);
      $display("watchdog expired after %0d cycles, the test sequence hung", watchdog_cycles);
      $display("Result: FAILED");
      $finish;
   end

   // Galois LFSR with taps 32, 22, 2 and 1, one step per bit
   function automatic logic lfsr_bit();
      logic out_bit;
      out_bit = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (out_bit)
         lfsr_state = lfsr_state ^ 32'h8020_0003;
      return out_bit;
   endfunction

   function automatic logic [31:0] lfsr_bits(input int count);
      logic [31:0] value;
      int i;
      value = '0;
      for (i = 0; i < count; i++)
         value = {value[30:0], lfsr_bit()};
      return value;
   endfunction

   task automatic check_value(input string test_name, input logic [31:0] expected,
      input logic [31:0] actual);
      check_count++;
      if (actual !== expected)
      begin
         error_count++;
         $display("Fail %s: expected %h, actual %h", test_name, expected, actual);
      end
   endtask

   `include "tb_tasks.svh"

   initial
   begin
      error_count = 0;
      check_count = 0;
      lfsr_state = 32'h26cb0893;
      exp_ctrl = 1'b0;
      exp_alloc = 1'b0;
      exp_base = '0;
      rst_n <= 1'b0;
      psel <= 1'b0;
      penable <= 1'b0;
      pwrite <= 1'b0;
      paddr <= '0;
      pwdata <= '0;
      host_addr <= '0;
      dram_v <= 1'b0;
      dram_addr <= '0;
      repeat (reset_cycles) @(posedge aclk);
      rst_n <= 1'b1;

      reset_values_test();
      register_access_test();
      error_response_test();
      host_window_test();
      dram_translate_test();
      profiler_test();

      $display("%0d checks run, %0d errors", check_count, error_count);
      if (error_count == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule
